/* design/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address width
`define CPU_XLEN 32

// Architectural registers, indexed by 5-bit fields
`define CPU_NREGS 32

// Single trap target for every exception cause
`define CPU_EXC_VECTOR 32'h0000_0200

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

/* design/cpuIsaPkg.sv */
`default_nettype none

package cpuIsaPkg;

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_ADDIU = 6'h09
  } opcodeT;

  // R-type funct field, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL = 6'h00,
    FN_SRL = 6'h02,
    FN_SRA = 6'h03,
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_SLT = 6'h2A
  } functT;

endpackage

`default_nettype wire

/* design/cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_SHIFT,
    ST_WRITEBACK,
    ST_TRAP
  } fsmStateT;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_SLT,
    ALU_PASS_B  // Also routes the shifter result to writeback
  } aluOpT;

  typedef enum logic [1:0] {
    SH_LEFT,
    SH_RIGHT_LOGICAL,
    SH_RIGHT_ARITH
  } shiftOpT;

  typedef enum logic [1:0] {
    PC_PLUS4,
    PC_BRANCH,
    PC_JUMP,
    PC_VECTOR
  } pcSelT;

  typedef enum logic {
    EXC_ILLEGAL,
    EXC_OVERFLOW
  } excCauseT;

endpackage

`default_nettype wire

/* design/stepCounter.sv */
`default_nettype none

module stepCounter (
  input  logic       clk,
  input  logic       reset_in,
  input  logic       load,
  input  logic [4:0] loadValue,
  input  logic       run,
  output logic       done
);

  logic [4:0] count;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      count <= '0;
    end else if (load) begin
      count <= loadValue;
    end else if (run && count != 5'd0) begin
      count <= count - 5'd1;  // One shift step per cycle
    end
  end

  // Last step in flight, or nothing to do at all
  assign done = (count <= 5'd1);

endmodule

`default_nettype wire

/* design/regFile.sv */
`default_nettype none
`include "cpu_config.svh"

module regFile (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic [4:0]           readAddrA,
  input  logic [4:0]           readAddrB,
  output logic [`CPU_XLEN-1:0] readDataA,
  output logic [`CPU_XLEN-1:0] readDataB,
  input  logic                 writeEnable,
  input  logic [4:0]           writeAddr,
  input  logic [`CPU_XLEN-1:0] writeData
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk) begin
    if (reset_in) begin
      for (int i = 0; i < `CPU_NREGS; i++)
        regs[i] <= '0;
    end else if (writeEnable && writeAddr != 5'd0) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Register 0 is hardwired
  assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
  assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

/* design/aluCore.sv */
`default_nettype none
`include "cpu_config.svh"

module aluCore (
  input  logic [`CPU_XLEN-1:0] opA,
  input  logic [`CPU_XLEN-1:0] opB,
  input  cpuCtrlPkg::aluOpT    op,
  output logic [`CPU_XLEN-1:0] result,
  output logic                 overflow,
  output logic                 zero
);
  import cpuCtrlPkg::*;

  localparam int MSB = `CPU_XLEN - 1;

  logic [`CPU_XLEN-1:0] sum;
  logic [`CPU_XLEN-1:0] diff;
  logic                 lessThan;

  assign sum      = opA + opB;
  assign diff     = opA - opB;
  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    overflow = 1'b0;
    case (op)
      ALU_ADD: begin
        result   = sum;
        overflow = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);  // Like signs only
      end
      ALU_SUB: begin
        result   = diff;
        overflow = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);
      end
      ALU_AND: result = opA & opB;
      ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, lessThan};
      default: result = opB;
    endcase
  end

  assign zero = (result == '0);  // Equality test for branches

endmodule

`default_nettype wire

/* design/shiftUnit.sv */
`default_nettype none
`include "cpu_config.svh"

module shiftUnit (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic                 load,
  input  logic                 step,
  input  cpuCtrlPkg::shiftOpT  op,
  input  logic [`CPU_XLEN-1:0] operand,
  output logic [`CPU_XLEN-1:0] result
);
  import cpuCtrlPkg::*;

  localparam int MSB = `CPU_XLEN - 1;

  logic [`CPU_XLEN-1:0] data;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      data <= '0;
    end else if (load) begin
      data <= operand;
    end else if (step) begin
      case (op)
        SH_LEFT:          data <= {data[MSB-1:0], 1'b0};
        SH_RIGHT_LOGICAL: data <= {1'b0, data[MSB:1]};
        SH_RIGHT_ARITH:   data <= {data[MSB], data[MSB:1]};  // Sign bit refills
        default:          data <= data;
      endcase
    end
  end

  assign result = data;

endmodule

`default_nettype wire

/* design/pcUnit.sv */
`default_nettype none
`include "cpu_config.svh"

module pcUnit (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic                 pcWrite,
  input  cpuCtrlPkg::pcSelT    pcSel,
  input  logic [`CPU_XLEN-1:0] branchOffset,
  input  logic [25:0]          jumpIndex,
  input  logic                 trap,
  output logic [`CPU_XLEN-1:0] pc,
  output logic [`CPU_XLEN-1:0] epc
);
  import cpuCtrlPkg::*;

  logic [`CPU_XLEN-1:0] pcPlus4;
  logic [`CPU_XLEN-1:0] nextPc;

  assign pcPlus4 = pc + 4;

  always_comb begin
    case (pcSel)
      PC_PLUS4:  nextPc = pcPlus4;
      PC_BRANCH: nextPc = pcPlus4 + {branchOffset[`CPU_XLEN-3:0], 2'b00};  // Word offset
      PC_JUMP:   nextPc = {pcPlus4[`CPU_XLEN-1:28], jumpIndex, 2'b00};    // Same 256 MB region
      default:   nextPc = `CPU_EXC_VECTOR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      pc  <= `CPU_RESET_PC;
      epc <= '0;
    end else begin
      if (pcWrite)
        pc <= nextPc;
      if (trap)
        epc <= pc;  // PC still points at the faulting instruction
    end
  end

endmodule

`default_nettype wire

/* design/controlFsm.sv */
`default_nettype none
`include "cpu_config.svh"

module controlFsm (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic [`CPU_XLEN-1:0] instr,
  input  logic                 instrValid,
  output logic                 instrReady,
  input  logic                 aluOverflow,
  input  logic                 aluZero,
  input  logic                 shiftDone,
  output cpuCtrlPkg::aluOpT    aluOp,
  output logic                 aluSrcImm,
  output cpuCtrlPkg::shiftOpT  shiftOp,
  output logic                 shiftLoad,
  output logic                 shiftStep,
  output logic [4:0]           rs,
  output logic [4:0]           rt,
  output logic [4:0]           rd,
  output logic [`CPU_XLEN-1:0] imm,
  output logic                 regWrite,
  output logic                 pcWrite,
  output cpuCtrlPkg::pcSelT    pcSel,
  output logic [25:0]          jumpIndex,
  output logic                 wbValid,
  output logic                 excValid,
  output cpuCtrlPkg::excCauseT excCause
);
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  fsmStateT             state;
  logic [`CPU_XLEN-1:0] ir;
  opcodeT               opcode;
  functT                funct;
  logic [4:0]           shamt;
  logic                 accept;
  logic                 illegal;
  logic                 isShift;
  logic                 isBranch;
  logic                 isJump;
  logic                 trapsOvf;
  logic                 branchTaken;

  assign opcode    = opcodeT'(ir[31:26]);
  assign funct     = functT'(ir[5:0]);
  assign shamt     = ir[10:6];
  assign rs        = ir[25:21];
  assign rt        = ir[20:16];
  assign rd        = (opcode == OP_RTYPE) ? ir[15:11] : ir[20:16];  // I-type writes rt
  assign imm       = {{(`CPU_XLEN-16){ir[15]}}, ir[15:0]};
  assign jumpIndex = ir[25:0];

  assign instrReady = (state == ST_FETCH);
  assign accept     = instrValid && instrReady;

  // Instruction class decode and ALU steering
  always_comb begin
    illegal   = 1'b0;
    isShift   = 1'b0;
    isBranch  = 1'b0;
    isJump    = 1'b0;
    trapsOvf  = 1'b0;
    aluSrcImm = 1'b0;
    aluOp     = ALU_ADD;
    shiftOp   = SH_LEFT;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FN_ADD: trapsOvf = 1'b1;
          FN_SUB: begin
            aluOp    = ALU_SUB;
            trapsOvf = 1'b1;
          end
          FN_AND: aluOp = ALU_AND;
          FN_SLT: aluOp = ALU_SLT;
          FN_SLL: begin
            aluOp   = ALU_PASS_B;
            isShift = 1'b1;
          end
          FN_SRL: begin
            aluOp   = ALU_PASS_B;
            shiftOp = SH_RIGHT_LOGICAL;
            isShift = 1'b1;
          end
          FN_SRA: begin
            aluOp   = ALU_PASS_B;
            shiftOp = SH_RIGHT_ARITH;
            isShift = 1'b1;
          end
          default: illegal = 1'b1;  // Unknown funct
        endcase
      end
      OP_ADDI: begin
        aluSrcImm = 1'b1;
        trapsOvf  = 1'b1;
      end
      OP_ADDIU: aluSrcImm = 1'b1;  // Wraps silently
      OP_BEQ, OP_BNE: begin
        aluOp    = ALU_SUB;
        isBranch = 1'b1;
      end
      OP_J: isJump = 1'b1;
      default: illegal = 1'b1;
    endcase
  end

  // BEQ wants zero and BNE wants nonzero
  assign branchTaken = isBranch && ((opcode == OP_BEQ) == aluZero);

  assign shiftLoad = (state == ST_DECODE) && isShift;
  assign shiftStep = (state == ST_SHIFT) && (shamt != 5'd0);  // Zero shamt never steps
  assign wbValid   = (state == ST_WRITEBACK) && (rd != 5'd0);
  assign regWrite  = wbValid;
  assign excValid  = (state == ST_TRAP);
  assign pcWrite   = ((state == ST_EXECUTE) && (isBranch || isJump)) ||
                     (state == ST_WRITEBACK) || excValid;

  always_comb begin
    if (state == ST_TRAP)
      pcSel = PC_VECTOR;
    else if (state == ST_EXECUTE && isJump)
      pcSel = PC_JUMP;
    else if (state == ST_EXECUTE && branchTaken)
      pcSel = PC_BRANCH;
    else
      pcSel = PC_PLUS4;
  end

  always_ff @(posedge clk) begin
    if (accept)
      ir <= instr;
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state    <= ST_FETCH;
      excCause <= EXC_ILLEGAL;
    end else begin
      case (state)
        ST_FETCH: begin
          if (accept)
            state <= ST_DECODE;
        end
        ST_DECODE: state <= isShift ? ST_SHIFT : ST_EXECUTE;
        ST_EXECUTE: begin
          if (illegal) begin
            state    <= ST_TRAP;
            excCause <= EXC_ILLEGAL;
          end else if (trapsOvf && aluOverflow) begin
            state    <= ST_TRAP;
            excCause <= EXC_OVERFLOW;
          end else if (isBranch || isJump) begin
            state <= ST_FETCH;  // PC already redirected
          end else begin
            state <= ST_WRITEBACK;
          end
        end
        ST_SHIFT: begin
          if (shiftDone)
            state <= ST_WRITEBACK;
        end
        default: state <= ST_FETCH;  // WRITEBACK and TRAP
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/cpuTop.sv */
`default_nettype none
`include "cpu_config.svh"

module cpuTop (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic [`CPU_XLEN-1:0] instr,
  input  logic                 instrValid,
  output logic                 instrReady,
  output logic [`CPU_XLEN-1:0] instrAddr,
  output logic                 wbValid,
  output logic [4:0]           wbReg,
  output logic [`CPU_XLEN-1:0] wbData,
  output logic                 excValid,
  output cpuCtrlPkg::excCauseT excCause,
  output logic [`CPU_XLEN-1:0] epc
);
  import cpuCtrlPkg::*;

  aluOpT                aluOp;
  shiftOpT              shiftOp;
  pcSelT                pcSel;
  logic                 aluSrcImm;
  logic                 aluOverflow;
  logic                 aluZero;
  logic                 shiftLoad;
  logic                 shiftStep;
  logic                 shiftDone;
  logic                 regWrite;
  logic                 pcWrite;
  logic [4:0]           rs;
  logic [4:0]           rt;
  logic [4:0]           rd;
  logic [25:0]          jumpIndex;
  logic [`CPU_XLEN-1:0] imm;
  logic [`CPU_XLEN-1:0] readDataA;
  logic [`CPU_XLEN-1:0] readDataB;
  logic [`CPU_XLEN-1:0] shiftResult;
  logic [`CPU_XLEN-1:0] aluResult;

  controlFsm controlFsm_i (
    .clk(clk), .reset_in(reset_in),
    .instr(instr), .instrValid(instrValid), .instrReady(instrReady),
    .aluOverflow(aluOverflow), .aluZero(aluZero), .shiftDone(shiftDone),
    .aluOp(aluOp), .aluSrcImm(aluSrcImm),
    .shiftOp(shiftOp), .shiftLoad(shiftLoad), .shiftStep(shiftStep),
    .rs(rs), .rt(rt), .rd(rd), .imm(imm),
    .regWrite(regWrite), .pcWrite(pcWrite), .pcSel(pcSel), .jumpIndex(jumpIndex),
    .wbValid(wbValid), .excValid(excValid), .excCause(excCause)
  );

  // Shift amount sits in imm[10:6] of the sign-extended immediate
  stepCounter stepCounter_i (
    .clk(clk), .reset_in(reset_in),
    .load(shiftLoad), .loadValue(imm[10:6]), .run(shiftStep), .done(shiftDone)
  );

  regFile regFile_i (
    .clk(clk), .reset_in(reset_in),
    .readAddrA(rs), .readAddrB(rt), .readDataA(readDataA), .readDataB(readDataB),
    .writeEnable(regWrite), .writeAddr(rd), .writeData(aluResult)
  );

  // PASS_B carries the shifter result, otherwise register or immediate
  aluCore aluCore_i (
    .opA(readDataA),
    .opB((aluOp == ALU_PASS_B) ? shiftResult : (aluSrcImm ? imm : readDataB)),
    .op(aluOp), .result(aluResult), .overflow(aluOverflow), .zero(aluZero)
  );

  shiftUnit shiftUnit_i (
    .clk(clk), .reset_in(reset_in),
    .load(shiftLoad), .step(shiftStep), .op(shiftOp),
    .operand(readDataB), .result(shiftResult)
  );

  pcUnit pcUnit_i (
    .clk(clk), .reset_in(reset_in),
    .pcWrite(pcWrite), .pcSel(pcSel), .branchOffset(imm), .jumpIndex(jumpIndex),
    .trap(excValid), .pc(instrAddr), .epc(epc)
  );

  assign wbReg  = rd;         // Destination index reported with the write
  assign wbData = aluResult;

endmodule

`default_nettype wire

/* tb/cpuTb_sva.sv */
`default_nettype none
`include "cpu_config.svh"

module protocolChecks (
  input logic                 clk,
  input logic                 reset_in,
  input logic                 instrValid,
  input logic                 instrReady,
  input logic [`CPU_XLEN-1:0] instrAddr,
  input logic                 wbValid,
  input logic [4:0]           wbReg,
  input logic                 excValid,
  input logic                 pcWrite
);
  timeunit 1ns;
  timeprecision 100ps;

  int failCount = 0;

  resetQuiet: assert property (@(posedge clk)
    reset_in |=> (!wbValid && !excValid && instrReady))
    else begin
      $error("Report pulse or blocked fetch right after reset");
      failCount++;
    end

  oneReport: assert property (@(posedge clk) disable iff (reset_in)
    !(wbValid && excValid))
    else begin
      $error("Writeback and exception reported in the same cycle");
      failCount++;
    end

  noZeroWrite: assert property (@(posedge clk) disable iff (reset_in)
    wbValid |-> (wbReg != 5'd0))
    else begin
      $error("Write to register 0 was reported");
      failCount++;
    end

  // Fetch closes on the accepting edge
  busyAfterAccept: assert property (@(posedge clk) disable iff (reset_in)
    (instrValid && instrReady) |=> !instrReady)
    else begin
      $error("Core still ready after accepting an instruction");
      failCount++;
    end

  // Every closing state also writes the PC
  readyAfterRetire: assert property (@(posedge clk) disable iff (reset_in)
    $rose(instrReady) |-> $past(pcWrite))
    else begin
      $error("Fetch reopened before WRITEBACK, EXECUTE or TRAP ended");
      failCount++;
    end

  holdAddr: assert property (@(posedge clk) disable iff (reset_in)
    (instrReady && !instrValid) |=> $stable(instrAddr))
    else begin
      $error("Fetch address moved while the instruction port stalled");
      failCount++;
    end

endmodule

bind cpuTop protocolChecks protocolChecks_i (
  .clk(clk),
  .reset_in(reset_in),
  .instrValid(instrValid),
  .instrReady(instrReady),
  .instrAddr(instrAddr),
  .wbValid(wbValid),
  .wbReg(wbReg),
  .excValid(excValid),
  .pcWrite(pcWrite)
);

`default_nettype wire

/* tb/cpuTb.sv */
`default_nettype none
`include "cpu_config.svh"

module cpuTb;
  timeunit 1ns;
  timeprecision 100ps;
  import cpuIsaPkg::*;
  import cpuCtrlPkg::*;

  localparam int MSB              = `CPU_XLEN - 1;
  localparam int NUM_INSTR        = 400;
  localparam int MAX_INSTR_CYCLES = 36;  // Longest shift plus fetch, decode and writeback
  localparam int CYCLE_LIMIT      = NUM_INSTR * MAX_INSTR_CYCLES + 1600;

  logic                 clk;
  logic                 reset_in;
  logic [`CPU_XLEN-1:0] instr;
  logic                 instrValid;
  logic                 instrReady;
  logic [`CPU_XLEN-1:0] instrAddr;
  logic                 wbValid;
  logic [4:0]           wbReg;
  logic [`CPU_XLEN-1:0] wbData;
  logic                 excValid;
  excCauseT             excCause;
  logic [`CPU_XLEN-1:0] epc;

  logic [`CPU_XLEN-1:0] prog [256];  // Indexed by instrAddr[9:2]
  logic [`CPU_XLEN-1:0] modelRegs [`CPU_NREGS];
  logic [`CPU_XLEN-1:0] modelPc;
  logic                 expWbPending;
  logic [4:0]           expWbReg;
  logic [`CPU_XLEN-1:0] expWbData;
  logic                 expExcPending;
  excCauseT             expCause;
  logic [`CPU_XLEN-1:0] expEpc;
  logic                 epcCheckDue;
  logic                 finished;
  logic [31:0]          stimRand;
  integer               seed;
  int                   accepted;
  int                   checkCount;
  int                   errorCount;
  int                   cycleCount;

  cpuTop cpuTop_i (
    .clk(clk), .reset_in(reset_in),
    .instr(instr), .instrValid(instrValid), .instrReady(instrReady), .instrAddr(instrAddr),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .excValid(excValid), .excCause(excCause), .epc(epc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fillProgram();
    logic [31:0] r;
    logic [31:0] pick;
    logic [4:0]  rsI;
    logic [4:0]  rtI;
    logic [4:0]  rdI;
    logic [15:0] imm16;
    int          i;
    for (i = 0; i < 256; i++) begin
      r     = $random(seed);
      pick  = $random(seed);
      rsI   = {2'b00, r[2:0]};  // Eight registers keep operands reused
      rtI   = {2'b00, r[5:3]};
      rdI   = {2'b00, r[8:6]};
      imm16 = (r[31:30] == 2'b11) ? {r[29], {15{~r[29]}}} : r[31:16];  // Extremes now and then
      case (pick[3:0])
        4'd0, 4'd1: prog[i] = {OP_RTYPE, rsI, rtI, rdI, 5'd0, FN_ADD};
        4'd2:       prog[i] = {OP_RTYPE, rsI, rtI, rdI, 5'd0, FN_SUB};
        4'd3:       prog[i] = {OP_RTYPE, rsI, rtI, rdI, 5'd0, FN_AND};
        4'd4:       prog[i] = {OP_RTYPE, rsI, rtI, rdI, 5'd0, FN_SLT};
        4'd5:       prog[i] = {OP_RTYPE, 5'd0, rtI, rdI, pick[8:4], FN_SLL};
        4'd6:       prog[i] = {OP_RTYPE, 5'd0, rtI, rdI, pick[8:4], FN_SRL};
        4'd7:       prog[i] = {OP_RTYPE, 5'd0, rtI, rdI, pick[8:4], FN_SRA};
        4'd8, 4'd9: prog[i] = {OP_ADDI, rsI, rtI, imm16};
        4'd10:      prog[i] = {OP_ADDIU, rsI, rtI, imm16};
        4'd11:      prog[i] = {OP_BEQ, rsI, rtI, {{10{pick[9]}}, pick[9:4]}};
        4'd12:      prog[i] = {OP_BNE, rsI, rtI, {{10{pick[9]}}, pick[9:4]}};
        4'd13:      prog[i] = {OP_J, 18'd0, pick[11:4]};  // Stays inside the program window
        4'd14:      prog[i] = {1'b1, pick[8:4], r[25:0]};  // Opcodes 0x20 to 0x3F
        default:    prog[i] = {OP_RTYPE, r[25:6], 2'b11, pick[7:4]};  // Functs 0x30 to 0x3F
      endcase
    end
  endtask

  // Reference execution of one accepted word
  task automatic executeModel(input logic [`CPU_XLEN-1:0] word);
    logic [5:0]           opc;
    logic [5:0]           fn;
    logic [4:0]           dest;
    logic [4:0]           sh;
    logic [`CPU_XLEN-1:0] a;
    logic [`CPU_XLEN-1:0] b;
    logic [`CPU_XLEN-1:0] immX;
    logic [`CPU_XLEN-1:0] pc4;
    logic [`CPU_XLEN-1:0] res;
    logic [`CPU_XLEN-1:0] nextPc;
    logic [`CPU_XLEN:0]   wide;
    logic                 writes;
    logic                 illegal;
    logic                 ovf;
    opc     = word[31:26];
    fn      = word[5:0];
    sh      = word[10:6];
    a       = modelRegs[word[25:21]];
    b       = modelRegs[word[20:16]];
    immX    = {{(`CPU_XLEN-16){word[15]}}, word[15:0]};
    pc4     = modelPc + 32'd4;
    dest    = word[20:16];
    res     = '0;
    nextPc  = pc4;
    wide    = '0;
    writes  = 1'b1;
    illegal = 1'b0;
    ovf     = 1'b0;
    case (opc)
      OP_RTYPE: begin
        dest = word[15:11];
        case (fn)
          FN_ADD: begin
            wide = {a[MSB], a} + {b[MSB], b};
            res  = wide[MSB:0];
            ovf  = wide[MSB+1] ^ wide[MSB];
          end
          FN_SUB: begin
            wide = {a[MSB], a} - {b[MSB], b};
            res  = wide[MSB:0];
            ovf  = wide[MSB+1] ^ wide[MSB];
          end
          FN_AND: res = a & b;
          FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          FN_SLL: res = b << sh;
          FN_SRL: res = b >> sh;
          FN_SRA: res = $signed(b) >>> sh;
          default: illegal = 1'b1;
        endcase
      end
      OP_ADDI: begin
        wide = {a[MSB], a} + {immX[MSB], immX};
        res  = wide[MSB:0];
        ovf  = wide[MSB+1] ^ wide[MSB];
      end
      OP_ADDIU: res = a + immX;  // No trap, wraps
      OP_BEQ: begin
        writes = 1'b0;
        if (a == b)
          nextPc = pc4 + (immX << 2);
      end
      OP_BNE: begin
        writes = 1'b0;
        if (a != b)
          nextPc = pc4 + (immX << 2);
      end
      OP_J: begin
        writes = 1'b0;
        nextPc = {pc4[MSB:28], word[25:0], 2'b00};
      end
      default: illegal = 1'b1;
    endcase
    if (illegal || ovf) begin
      expExcPending = 1'b1;
      expCause      = illegal ? EXC_ILLEGAL : EXC_OVERFLOW;
      expEpc        = modelPc;
      modelPc       = `CPU_EXC_VECTOR;
    end else begin
      if (writes && dest != 5'd0) begin
        modelRegs[dest] = res;
        expWbPending    = 1'b1;
        expWbReg        = dest;
        expWbData       = res;
      end
      modelPc = nextPc;
    end
  endtask

  task automatic acceptInstr(input logic [`CPU_XLEN-1:0] word);
    checkCount++;
    assert (instrAddr == modelPc) else begin
      errorCount++;
      $display("mismatch at %0t: fetch address %h, expected %h", $time, instrAddr, modelPc);
    end
    assert (!expWbPending && !expExcPending) else begin
      errorCount++;
      $display("At %0t the previous instruction ended without reporting its result", $time);
    end
    expWbPending  = 1'b0;
    expExcPending = 1'b0;
    executeModel(word);
  endtask

  task automatic checkOutputs();
    if (wbValid) begin
      checkCount++;
      assert (expWbPending && wbReg == expWbReg && wbData == expWbData) else begin
        errorCount++;
        $display("mismatch at %0t: write r%0d = %h, expected r%0d = %h (expected %0b)",
                 $time, wbReg, wbData, expWbReg, expWbData, expWbPending);
      end
      expWbPending = 1'b0;
    end
    if (excValid) begin
      checkCount++;
      assert (expExcPending && excCause == expCause) else begin
        errorCount++;
        $display("mismatch at %0t: exception cause %0d, expected %0d (expected %0b)",
                 $time, excCause, expCause, expExcPending);
      end
      expExcPending = 1'b0;
      epcCheckDue   = 1'b1;  // EPC loads at the end of the trap cycle
    end else if (epcCheckDue) begin
      checkCount++;
      assert (epc == expEpc) else begin
        errorCount++;
        $display("mismatch at %0t: epc %h, expected %h", $time, epc, expEpc);
      end
      epcCheckDue = 1'b0;
    end
  endtask

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < CYCLE_LIMIT) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles with %0d instructions accepted", cycleCount, accepted);
    $display("Finished with errors");
    $finish;
  end

  initial begin : stimulus
    int protocolErrors;
    reset_in      = 1'b1;
    instr         = '0;
    instrValid    = 1'b0;
    seed          = 32'h797b;
    accepted      = 0;
    checkCount    = 0;
    errorCount    = 0;
    expWbPending  = 1'b0;
    expExcPending = 1'b0;
    epcCheckDue   = 1'b0;
    finished      = 1'b0;
    modelPc       = `CPU_RESET_PC;
    for (int r = 0; r < `CPU_NREGS; r++)
      modelRegs[r] = '0;
    fillProgram();
    repeat (5) @(posedge clk);
    #1;
    reset_in = 1'b0;
    while (!finished) begin
      @(posedge clk);
      #1;
      checkOutputs();
      stimRand   = $random(seed);
      instr      = prog[instrAddr[9:2]];
      instrValid = (accepted < NUM_INSTR) && (stimRand[1:0] != 2'b00);  // One in four stalls
      if (instrValid && instrReady) begin
        acceptInstr(instr);
        accepted++;
      end
      finished = (accepted >= NUM_INSTR) && instrReady && !instrValid && !epcCheckDue;
    end
    assert (!expWbPending && !expExcPending) else begin
      errorCount++;
      $display("The last instruction ended without reporting its result");
    end
    protocolErrors = cpuTop_i.protocolChecks_i.failCount;
    $display("Checks: %0d, model errors: %0d, protocol errors: %0d",
             checkCount, errorCount, protocolErrors);
    if (errorCount == 0 && protocolErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/cpuIsaPkg.sv
design/cpuCtrlPkg.sv
design/stepCounter.sv
design/regFile.sv
design/aluCore.sv
design/shiftUnit.sv
design/pcUnit.sv
design/controlFsm.sv
design/cpuTop.sv
tb/cpuTb_sva.sv
tb/cpuTb.sv

/* run.sh */
#!/bin/bash
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module cpuTb -f list.f -o cpuSim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/cpuSim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
